/* logic/pkt_scan_defines.svh */
`ifndef PKT_SCAN_DEFINES_SVH
`define PKT_SCAN_DEFINES_SVH

// Number of scanning lanes, one literal pattern each
`define SCAN_LANES 4

// Streams with a saved matcher state per lane
`define SCAN_STREAMS 64

// Literal length in bytes
`define SCAN_PAT_LEN 4

// Lane patterns, first byte to match in the top byte
// "GET "
`define SCAN_PATTERN_0 32'h4745_5420
// "POST"
`define SCAN_PATTERN_1 32'h504f_5354
// "HTTP"
`define SCAN_PATTERN_2 32'h4854_5450
// "abab" exercises the restart rule on overlapping input
`define SCAN_PATTERN_3 32'h6162_6162

`endif

/* logic/pkt_scan_pkg.sv */
package pkt_scan_pkg;

   // Stream number, indexes the per-lane state memories
   typedef logic [5:0] stream_id_t;

   // Matcher progress, 0 to 4 bytes matched
   typedef logic [2:0] dfa_state_t;

   // Header word, presented with sop
   typedef struct packed {
      logic       new_stream;
      logic       spare_hi;
      stream_id_t stream_id;
      logic [3:0] spare_lo;
      logic [3:0] lane_en;
   } scan_hdr_t;

   // Data word, one character in the low byte
   typedef struct packed {
      logic [7:0] spare;
      logic [7:0] char;
   } scan_data_t;

   // Same 16 bits read as header or data, sop decides
   typedef union packed {
      scan_hdr_t  hdr;
      scan_data_t data;
   } scan_word_u;

endpackage

/* logic/scan_lane_if.sv */
`timescale 1ns/100ps
`include "pkt_scan_defines.svh"

interface scan_lane_if;
   import pkt_scan_pkg::*;

   // Per-packet control, held from one header to the next
   logic                   load;
   logic                   new_stream;
   stream_id_t             stream_id;
   logic [`SCAN_LANES-1:0] enable_mask;

   // Per-byte strobes
   logic [7:0]             char;
   logic                   char_vld;
   logic                   eop;

   // Dispatcher side
   modport src (
      output load, new_stream, stream_id, enable_mask,
      output char, char_vld, eop
   );

   // Every lane sees the same broadcast
   modport sink (
      input load, new_stream, stream_id, enable_mask,
      input char, char_vld, eop
   );

endinterface

/* logic/scan_dispatch.sv */
`timescale 1ns/100ps

module scan_dispatch (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    word_vld,
   input  logic                    sop,
   input  logic                    eop,
   input  pkt_scan_pkg::scan_word_u word,
   scan_lane_if.src                lanes
);

   logic is_hdr;
   logic is_data;

   // sop marks a header, anything else valid is a data byte
   assign is_hdr  = word_vld & sop;
   assign is_data = word_vld & ~sop;

   // Strobes, one cycle behind the input word
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         lanes.load     <= 1'b0;
         lanes.char_vld <= 1'b0;
         lanes.eop      <= 1'b0;
      end
      else
      begin
         // Header opens a packet, lanes restore state
         lanes.load     <= is_hdr;
         lanes.char_vld <= is_data;
         // eop only rides on a data byte
         lanes.eop      <= is_data & eop;
      end
   end

   // Header fields, held until the next header
   // Lanes still need stream id and mask at eop
   always_ff @(posedge clk)
   begin
      if (is_hdr)
      begin
         lanes.new_stream  <= word.hdr.new_stream;
         lanes.stream_id   <= word.hdr.stream_id;
         lanes.enable_mask <= word.hdr.lane_en;
      end
   end

   // Character of a data word
   always_ff @(posedge clk)
   begin
      if (is_data)
      begin
         lanes.char <= word.data.char;
      end
   end

endmodule

/* logic/literal_dfa.sv */
`timescale 1ns/100ps
`include "pkt_scan_defines.svh"

module literal_dfa #(
   parameter logic [31:0] PATTERN = 32'h0
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     char_vld,
   input  logic                     state_in_vld,
   input  logic [7:0]               char,
   input  pkt_scan_pkg::dfa_state_t state_in,
   output pkt_scan_pkg::dfa_state_t state_out,
   output logic                     accept
);
   import pkt_scan_pkg::*;

   localparam int LEN = `SCAN_PAT_LEN;
   localparam logic [7:0] FIRST_BYTE = PATTERN[(LEN-1)*8 +: 8];

   dfa_state_t prog_q;
   dfa_state_t prog_eff;
   dfa_state_t prog_step;
   logic [7:0] expect_byte;

   // Full match restarts from zero on the next byte
   assign prog_eff = (prog_q == dfa_state_t'(LEN)) ? '0 : prog_q;

   // Pattern byte expected at this progress, top byte first
   assign expect_byte = PATTERN[(LEN - 1 - int'(prog_eff)) * 8 +: 8];

   // Restart rule
   always_comb
   begin
      if (char == expect_byte)
         prog_step = prog_eff + dfa_state_t'(1);
      else if (char == FIRST_BYTE)
         prog_step = dfa_state_t'(1);
      else
         prog_step = '0;
   end

   // Next state as the lane would save it
   // A load wins over a byte
   assign state_out = state_in_vld ? state_in :
                      char_vld     ? prog_step : prog_q;

   // High for the byte that completes the pattern
   assign accept = char_vld & ~state_in_vld & (prog_step == dfa_state_t'(LEN));

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         prog_q <= '0;
      else
         prog_q <= state_out;
   end

endmodule

/* logic/stream_match_lane.sv */
`timescale 1ns/100ps
`include "pkt_scan_defines.svh"

module stream_match_lane #(
   parameter int          LANE    = 0,
   parameter logic [31:0] PATTERN = 32'h0
) (
   input  logic        clk,
   input  logic        rst_n,
   scan_lane_if.sink   lanes,
   output logic        fired,
   output logic [15:0] count
);
   import pkt_scan_pkg::*;

   // Saved matcher progress, one entry per stream
   dfa_state_t state_mem [`SCAN_STREAMS];

   dfa_state_t restore_state;
   dfa_state_t state_out;
   logic       accept;
   logic       spec_match;
   logic       lane_en;

   // This lane's bit of the packet mask
   assign lane_en = lanes.enable_mask[LANE];

   // New stream starts clean, else pick up where it stopped
   assign restore_state = lanes.new_stream ? '0 : state_mem[lanes.stream_id];

   literal_dfa #(
      .PATTERN (PATTERN)
   ) u_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_vld     (lanes.char_vld),
      .state_in_vld (lanes.load),
      .char         (lanes.char),
      .state_in     (restore_state),
      .state_out    (state_out),
      .accept       (accept)
   );

   // Match seen so far in this packet, the eop byte included
   assign fired = spec_match | accept;

   // Speculative flag and count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         spec_match <= 1'b0;
         count      <= '0;
      end
      else
      begin
         // Flag lives for one packet only
         if (lanes.load || lanes.eop)
            spec_match <= 1'b0;
         else if (accept)
            spec_match <= 1'b1;
         // Commit only when enabled, otherwise the match is dropped
         if (lanes.eop && lane_en)
            count <= count + 16'(fired);
      end
   end

   // Save progress at eop of an enabled packet
   // Disabled packet leaves the older state in place
   always_ff @(posedge clk)
   begin
      if (lanes.eop && lane_en)
      begin
         state_mem[lanes.stream_id] <= state_out;
      end
   end

endmodule

/* logic/match_collect.sv */
`timescale 1ns/100ps
`include "pkt_scan_defines.svh"

module match_collect (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   eop,
   input  logic [`SCAN_LANES-1:0] enable_mask,
   input  logic [`SCAN_LANES-1:0] fired,
   input  logic [15:0]            lane_count [`SCAN_LANES],
   input  logic [1:0]             count_sel,
   output logic                   hit_vld,
   output logic [`SCAN_LANES-1:0] hit_mask,
   output logic [15:0]            count
);

   // Hit report, one pulse per packet
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         hit_vld  <= 1'b0;
         hit_mask <= '0;
      end
      else
      begin
         hit_vld <= eop;
         // Only enabled lanes report
         // Mask reads zero between reports
         if (eop)
            hit_mask <= fired & enable_mask;
         else
            hit_mask <= '0;
      end
   end

   // Count readout, follows count_sel directly
   assign count = lane_count[count_sel];

endmodule

/* logic/pkt_scan_top.sv */
`timescale 1ns/100ps
`include "pkt_scan_defines.svh"

module pkt_scan_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   word_vld,
   input  logic                   sop,
   input  logic                   eop,
   input  logic [15:0]            word,
   input  logic [1:0]             count_sel,
   output logic                   hit_vld,
   output logic [`SCAN_LANES-1:0] hit_mask,
   output logic [15:0]            count
);

   // Pattern per lane index
   localparam logic [31:0] LANE_PATTERN [`SCAN_LANES] = '{
      `SCAN_PATTERN_0, `SCAN_PATTERN_1, `SCAN_PATTERN_2, `SCAN_PATTERN_3
   };

   logic [`SCAN_LANES-1:0] fired;
   logic [15:0]            lane_count [`SCAN_LANES];

   // Broadcast control to all lanes
   scan_lane_if lanes_if ();

   scan_dispatch u_dispatch (
      .clk      (clk),
      .rst_n    (rst_n),
      .word_vld (word_vld),
      .sop      (sop),
      .eop      (eop),
      .word     (word),
      .lanes    (lanes_if)
   );

   // One lane per pattern
   for (genvar g = 0; g < `SCAN_LANES; g++)
   begin : g_lane
      stream_match_lane #(
         .LANE    (g),
         .PATTERN (LANE_PATTERN[g])
      ) u_lane (
         .clk   (clk),
         .rst_n (rst_n),
         .lanes (lanes_if),
         .fired (fired[g]),
         .count (lane_count[g])
      );
   end

   match_collect u_collect (
      .clk         (clk),
      .rst_n       (rst_n),
      .eop         (lanes_if.eop),
      .enable_mask (lanes_if.enable_mask),
      .fired       (fired),
      .lane_count  (lane_count),
      .count_sel   (count_sel),
      .hit_vld     (hit_vld),
      .hit_mask    (hit_mask),
      .count       (count)
   );

endmodule

/* sim/pkt_scan_asserts.sv */
`timescale 1ns/100ps
`include "pkt_scan_defines.svh"

module pkt_scan_asserts (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   sop,
   input logic                   eop,
   input logic                   load,
   input logic                   char_vld,
   input logic                   hit_vld,
   input logic [`SCAN_LANES-1:0] hit_mask
);

   // Running total of assertion failures
   int fail_count = 0;

   // One report per packet and never two cycles in a row
   a_hit_pulse : assert property (@(posedge clk) disable iff (!rst_n) hit_vld |=> !hit_vld)
      else
      begin
         $error("hit_vld held high for more than one cycle");
         fail_count++;
      end

   // Header load and data byte are separate cycles on the broadcast
   a_load_vs_char : assert property (@(posedge clk) disable iff (!rst_n) !(load && char_vld))
      else
      begin
         $error("load and char_vld high together on the lane interface");
         fail_count++;
      end

   // Mask only carries meaning with the valid pulse
   a_mask_idle : assert property (@(posedge clk) disable iff (!rst_n) !hit_vld |-> hit_mask == '0)
      else
      begin
         $error("hit_mask nonzero while hit_vld is low");
         fail_count++;
      end

   // A header never closes a packet
   a_sop_eop : assert property (@(posedge clk) disable iff (!rst_n) !(sop && eop))
      else
      begin
         $error("sop and eop presented together");
         fail_count++;
      end

endmodule

/* sim/pkt_scan_tb.sv */
`timescale 1ns/100ps
`include "pkt_scan_defines.svh"

module pkt_scan_tb;

   // Lane patterns for the reference model with the first byte on top
   localparam logic [31:0] PAT [`SCAN_LANES] = '{
      `SCAN_PATTERN_0, `SCAN_PATTERN_1, `SCAN_PATTERN_2, `SCAN_PATTERN_3
   };
   localparam int HIT_TIMEOUT = 20;

   logic        clk;
   logic        rst_n;
   logic        word_vld;
   logic        sop;
   logic        eop;
   logic [15:0] word;
   logic [1:0]  count_sel;
   logic        hit_vld;
   logic [3:0]  hit_mask;
   logic [15:0] count;

   // Packet table with one entry per index across the queues
   bit          tbl_new  [$];
   logic [5:0]  tbl_sid  [$];
   logic [3:0]  tbl_mask [$];
   int          tbl_gap  [$];
   string       tbl_data [$];

   // Reference model state
   logic [2:0]  model_state [`SCAN_LANES][`SCAN_STREAMS];
   logic [15:0] model_count [`SCAN_LANES];
   logic [7:0]  cur_bytes [$];
   integer      seed;
   int          pkt_num;
   string       alphabet = "abGETPOSH ";

   pkt_scan_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .word_vld  (word_vld),
      .sop       (sop),
      .eop       (eop),
      .word      (word),
      .count_sel (count_sel),
      .hit_vld   (hit_vld),
      .hit_mask  (hit_mask),
      .count     (count)
   );

   // Protocol checks on the top level and the lane broadcast
   bind pkt_scan_top pkt_scan_asserts u_asserts (
      .clk      (clk),
      .rst_n    (rst_n),
      .sop      (sop),
      .eop      (eop),
      .load     (lanes_if.load),
      .char_vld (lanes_if.char_vld),
      .hit_vld  (hit_vld),
      .hit_mask (hit_mask)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Error: %s is 0x%0h, expected 0x%0h (packet %0d)", name, got, exp, pkt_num);
         $display("SOME TESTS FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // A failed protocol assertion ends the run at once
   always @(negedge clk)
   begin
      check_value("assertion failures", 32'(u_dut.u_asserts.fail_count), 32'd0);
   end

   task automatic add_entry(input bit ns, input logic [5:0] sid, input logic [3:0] mask,
                            input string data, input int gap);
      tbl_new.push_back(ns);
      tbl_sid.push_back(sid);
      tbl_mask.push_back(mask);
      tbl_data.push_back(data);
      tbl_gap.push_back(gap);
   endtask

   task automatic load_table();
      // Whole pattern inside one packet
      add_entry(1'b1, 6'd0, 4'hf, "xGET y", 0);
      add_entry(1'b1, 6'd1, 4'hf, "POSTHTTP", 2);
      // Split over two packets continued and then restarted
      add_entry(1'b1, 6'd2, 4'hf, "zzHT", 0);
      add_entry(1'b0, 6'd2, 4'hf, "TPzz", 1);
      add_entry(1'b1, 6'd2, 4'hf, "zHT", 0);
      add_entry(1'b1, 6'd2, 4'hf, "TP", 0);
      // Two streams interleaved
      add_entry(1'b1, 6'd3, 4'hf, "GE", 0);
      add_entry(1'b1, 6'd4, 4'hf, "POS", 3);
      add_entry(1'b0, 6'd3, 4'hf, "T ", 0);
      add_entry(1'b0, 6'd4, 4'hf, "T", 0);
      // Lane 3 off for one packet so the older state survives
      add_entry(1'b1, 6'd5, 4'hf, "ab", 0);
      add_entry(1'b0, 6'd5, 4'h7, "zz", 0);
      add_entry(1'b0, 6'd5, 4'hf, "ab", 0);
      add_entry(1'b1, 6'd6, 4'he, "GET ", 1);
      // Overlap and restart with a match on the eop byte
      add_entry(1'b1, 6'd7, 4'hf, "aabab", 0);
      add_entry(1'b0, 6'd7, 4'hf, "ababab", 0);
      add_entry(1'b0, 6'd7, 4'hf, "ab", 0);
   endtask

   // Predicts hit bits and updates counts and saved states
   task automatic model_packet(input bit ns, input logic [5:0] sid, input logic [3:0] mask,
                               output logic [3:0] hit);
      logic [2:0] prog;
      logic [7:0] want;
      bit         flag;
      hit = '0;
      for (int l = 0; l < `SCAN_LANES; l++)
      begin
         prog = ns ? 3'd0 : model_state[l][sid];
         flag = 1'b0;
         foreach (cur_bytes[i])
         begin
            // After a full match the next byte starts from zero
            if (prog == 3'd4)
               prog = 3'd0;
            want = 8'(PAT[l] >> (8 * (3 - int'(prog))));
            if (cur_bytes[i] == want)
               prog = prog + 3'd1;
            else if (cur_bytes[i] == PAT[l][31:24])
               prog = 3'd1;
            else
               prog = 3'd0;
            if (prog == 3'd4)
               flag = 1'b1;
         end
         // Disabled lane drops the match and keeps its old state
         if (mask[l])
         begin
            model_count[l] = model_count[l] + 16'(flag);
            model_state[l][sid] = prog;
            hit[l] = flag;
         end
      end
   endtask

   task automatic drive_word(input logic s, input logic e, input logic [15:0] w);
      @(posedge clk);
      word_vld <= 1'b1;
      sop      <= s;
      eop      <= e;
      word     <= w;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      word_vld <= 1'b0;
      sop      <= 1'b0;
      eop      <= 1'b0;
   endtask

   // Counts falling edges until the hit report
   task automatic wait_hit(output int latency);
      int n;
      bit seen;
      n = 0;
      seen = 1'b0;
      while (!seen && n < HIT_TIMEOUT)
      begin
         @(negedge clk);
         n++;
         seen = hit_vld;
      end
      if (!seen)
      begin
         $display("Timeout: hit_vld never pulsed after packet %0d", pkt_num);
         $display("SOME TESTS FAILED");
         $fatal(1, "No hit report");
      end
      latency = n;
   endtask

   task automatic check_counts();
      for (int l = 0; l < `SCAN_LANES; l++)
      begin
         @(posedge clk);
         count_sel <= 2'(l);
         @(negedge clk);
         check_value($sformatf("count[%0d]", l), 32'(count), 32'(model_count[l]));
      end
   endtask

   // Header, optional idle gap, then the bytes in cur_bytes
   task automatic run_packet(input bit ns, input logic [5:0] sid, input logic [3:0] mask,
                             input int gap);
      logic [3:0] exp_hit;
      int         latency;
      model_packet(ns, sid, mask, exp_hit);
      drive_word(1'b1, 1'b0, {ns, 1'b0, sid, 4'h0, mask});
      repeat (gap) drive_idle();
      foreach (cur_bytes[i])
         drive_word(1'b0, i == cur_bytes.size() - 1, {8'h00, cur_bytes[i]});
      drive_idle();
      wait_hit(latency);
      check_value("hit latency", 32'(latency), 32'd2);
      check_value("hit_mask", 32'(hit_mask), 32'(exp_hit));
      check_counts();
      pkt_num++;
   endtask

   initial
   begin
      string      s;
      int         fsid;
      int         flen;
      bit         fnew;
      logic [3:0] fmask;
      bit         filler_init [4];
      rst_n     = 1'b0;
      word_vld  = 1'b0;
      sop       = 1'b0;
      eop       = 1'b0;
      word      = '0;
      count_sel = '0;
      seed      = 32'h368e_1b0e;
      pkt_num   = 0;
      filler_init = '{default: 1'b0};
      for (int l = 0; l < `SCAN_LANES; l++)
         model_count[l] = '0;
      load_table();
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      // Quiet outputs and zero counts straight after reset
      @(negedge clk);
      check_value("hit_vld", 32'(hit_vld), 32'd0);
      check_value("hit_mask", 32'(hit_mask), 32'd0);
      check_counts();
      for (int t = 0; t < tbl_new.size(); t++)
      begin
         cur_bytes.delete();
         s = tbl_data[t];
         for (int i = 0; i < s.len(); i++)
            cur_bytes.push_back(s[i]);
         run_packet(tbl_new[t], tbl_sid[t], tbl_mask[t], tbl_gap[t]);
      end
      // Random filler on streams 40 to 43 with the first use of a stream fully enabled
      for (int p = 0; p < 24; p++)
      begin
         fsid  = $unsigned($random(seed)) % 4;
         fnew  = !filler_init[fsid] || (($random(seed) & 7) == 0);
         fmask = filler_init[fsid] ? 4'($random(seed)) : 4'hf;
         filler_init[fsid] = 1'b1;
         flen  = 1 + $unsigned($random(seed)) % 12;
         cur_bytes.delete();
         for (int i = 0; i < flen; i++)
            cur_bytes.push_back(alphabet[$unsigned($random(seed)) % alphabet.len()]);
         run_packet(fnew, 6'(40 + fsid), fmask, $unsigned($random(seed)) % 3);
      end
      check_value("assertion failures", 32'(u_dut.u_asserts.fail_count), 32'd0);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* pkt_scan_top.f */
+incdir+logic
logic/pkt_scan_pkg.sv
logic/scan_lane_if.sv
logic/scan_dispatch.sv
logic/literal_dfa.sv
logic/stream_match_lane.sv
logic/match_collect.sv
logic/pkt_scan_top.sv
sim/pkt_scan_asserts.sv
sim/pkt_scan_tb.sv

/* Bender.yml */
package:
  name: pkt_scan

sources:
  - include_dirs:
      - logic
    files:
      - logic/pkt_scan_pkg.sv
      - logic/scan_lane_if.sv
      - logic/scan_dispatch.sv
      - logic/literal_dfa.sv
      - logic/stream_match_lane.sv
      - logic/match_collect.sv
      - logic/pkt_scan_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/pkt_scan_asserts.sv
      - sim/pkt_scan_tb.sv
